//--- logic/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int mem_depth = 2048;
    localparam int addr_width = 11;

    // upper nibble of every control byte.
    localparam logic [3:0] device_code = 4'b1010;

    typedef logic [addr_width-1:0] mem_addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [2:0] block_t;

    // one access to the shared byte memory.
    typedef struct packed {
        logic      valid;
        logic      we;
        mem_addr_t addr;
        byte_t     wdata;
    } mem_req_t;

    typedef struct packed {
        logic scl;      // synchronized levels.
        logic sdat;
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
    } line_events_t;

    typedef enum logic [3:0] {
        idle,
        control,
        control_ack,
        address,
        address_ack,
        write_data,
        write_ack,
        read_data,
        read_ack
    } slave_state_t;

endpackage

`default_nettype wire

//--- logic/bus_line_sync.sv
`timescale 1ns/1ns
`default_nettype none

module bus_line_sync (
    input  wire                      sda,
    input  wire                      arst_n,
    input  wire                      scl,
    input  wire                      sdat_in,
    output eeprom_pkg::line_events_t events
);

    logic [1:0] scl_sync;
    logic [1:0] sdat_sync;
    logic       scl_now;
    logic       sdat_now;

    assign scl_now = scl_sync[1];
    assign sdat_now = sdat_sync[1];

    // events.scl and events.sdat double as the previous sample.
    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scl_sync <= 2'b11; // bus idles high.
            sdat_sync <= 2'b11;
            events <= '{scl: 1'b1, sdat: 1'b1, default: 1'b0};
        end
        else
        begin
            scl_sync <= {scl_sync[0], scl};
            sdat_sync <= {sdat_sync[0], sdat_in};
            events.scl <= scl_now;
            events.sdat <= sdat_now;
            events.scl_rise <= scl_now && !events.scl;
            events.scl_fall <= !scl_now && events.scl;
            // data moves while the clock stays high.
            events.start <= scl_now && events.scl && events.sdat && !sdat_now;
            events.stop <= scl_now && events.scl && !events.sdat && sdat_now;
        end
    end

endmodule

`default_nettype wire

//--- logic/serial_slave.sv
`timescale 1ns/1ns
`default_nettype none

module serial_slave (
    input  wire                           sda,
    input  wire                           arst_n,
    input  wire eeprom_pkg::line_events_t events,
    input  wire                           grant,
    input  wire eeprom_pkg::byte_t        rdata,
    output eeprom_pkg::mem_req_t          req,
    output logic                          sdat_pull
);

    eeprom_pkg::slave_state_t state;
    eeprom_pkg::byte_t        shift;   // byte coming in.
    eeprom_pkg::byte_t        tx;      // byte going out.
    eeprom_pkg::block_t       block;
    eeprom_pkg::mem_addr_t    pointer;
    logic [3:0]               bit_cnt;
    logic                     rw;
    logic                     master_ack;
    logic                     load_q;
    logic                     byte_full;
    logic                     take_bit;
    logic                     fetch;

    assign byte_full = bit_cnt == 4'd8;

    assign take_bit = events.scl_rise && !byte_full &&
                      (state == eeprom_pkg::control || state == eeprom_pkg::address ||
                       state == eeprom_pkg::write_data);

    // next read byte, requested on the ack clock so it is loaded before bit 7.
    assign fetch = events.scl_rise &&
                   ((state == eeprom_pkg::control_ack && rw) ||
                    (state == eeprom_pkg::read_ack && !events.sdat));

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= eeprom_pkg::idle;
            req <= '0;
            sdat_pull <= 1'b0;
            shift <= '0;
            tx <= '0;
            block <= '0;
            pointer <= '0;
            bit_cnt <= '0;
            rw <= 1'b0;
            master_ack <= 1'b0;
            load_q <= 1'b0;
        end
        else
        begin
            load_q <= grant && !req.we;
            if (grant)
                req.valid <= 1'b0;
            if (load_q)
                tx <= rdata;
            if (take_bit)
            begin
                shift <= {shift[6:0], events.sdat};
                bit_cnt <= bit_cnt + 4'd1;
            end
            if (fetch)
            begin
                req <= '{valid: 1'b1, we: 1'b0, addr: pointer, wdata: '0};
                pointer <= pointer + 1'b1;
            end

            if (events.stop)
            begin
                state <= eeprom_pkg::idle;
                sdat_pull <= 1'b0;
            end
            else if (events.start)
            begin
                state <= eeprom_pkg::control; // repeated start too.
                bit_cnt <= '0;
                sdat_pull <= 1'b0;
            end
            else if (events.scl_fall)
            begin
                case (state)
                    eeprom_pkg::control:
                    begin
                        if (byte_full)
                        begin
                            bit_cnt <= '0;
                            if (shift[7:4] == eeprom_pkg::device_code)
                            begin
                                block <= shift[3:1];
                                rw <= shift[0];
                                sdat_pull <= 1'b1;
                                state <= eeprom_pkg::control_ack;
                            end
                            else
                                state <= eeprom_pkg::idle; // not ours.
                        end
                    end
                    eeprom_pkg::control_ack:
                    begin
                        if (rw)
                        begin
                            sdat_pull <= !tx[7];
                            tx <= {tx[6:0], 1'b0};
                            bit_cnt <= 4'd1;
                            state <= eeprom_pkg::read_data;
                        end
                        else
                        begin
                            sdat_pull <= 1'b0;
                            state <= eeprom_pkg::address;
                        end
                    end
                    eeprom_pkg::address:
                    begin
                        if (byte_full)
                        begin
                            pointer <= {block, shift};
                            bit_cnt <= '0;
                            sdat_pull <= 1'b1;
                            state <= eeprom_pkg::address_ack;
                        end
                    end
                    eeprom_pkg::write_data:
                    begin
                        if (byte_full)
                        begin
                            req <= '{valid: 1'b1, we: 1'b1, addr: pointer, wdata: shift};
                            pointer <= pointer + 1'b1; // wraps at the top.
                            bit_cnt <= '0;
                            sdat_pull <= 1'b1;
                            state <= eeprom_pkg::write_ack;
                        end
                    end
                    eeprom_pkg::address_ack, eeprom_pkg::write_ack:
                    begin
                        sdat_pull <= 1'b0;
                        state <= eeprom_pkg::write_data;
                    end
                    eeprom_pkg::read_data:
                    begin
                        if (byte_full)
                        begin
                            sdat_pull <= 1'b0; // master owns the ack bit.
                            state <= eeprom_pkg::read_ack;
                        end
                        else
                        begin
                            sdat_pull <= !tx[7];
                            tx <= {tx[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    eeprom_pkg::read_ack:
                    begin
                        if (master_ack)
                        begin
                            sdat_pull <= !tx[7];
                            tx <= {tx[6:0], 1'b0};
                            bit_cnt <= 4'd1;
                            state <= eeprom_pkg::read_data;
                        end
                        else
                            state <= eeprom_pkg::idle;
                    end
                    default:
                        state <= eeprom_pkg::idle;
                endcase
            end
            else if (events.scl_rise && state == eeprom_pkg::read_ack)
                master_ack <= !events.sdat;
        end
    end

    // the arbiter must answer before the request moves.
    a_req_held: assert property (@(posedge sda) disable iff (!arst_n)
        req.valid && !grant |=> req.valid && $stable(req.addr));

    a_idle_quiet: assert property (@(posedge sda) disable iff (!arst_n)
        state == eeprom_pkg::idle |-> !sdat_pull);

endmodule

`default_nettype wire

//--- logic/host_port.sv
`timescale 1ns/1ns
`default_nettype none

module host_port (
    input  wire                        sda,
    input  wire                        arst_n,
    input  wire                        host_req,
    input  wire                        host_we,
    input  wire eeprom_pkg::mem_addr_t host_addr,
    input  wire eeprom_pkg::byte_t     host_wdata,
    input  wire                        grant,
    input  wire eeprom_pkg::byte_t     rdata,
    output eeprom_pkg::mem_req_t       req,
    output logic                       host_done,
    output eeprom_pkg::byte_t          host_rdata
);

    logic              grant_q;
    eeprom_pkg::byte_t rdata_q;

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            req <= '0;
            grant_q <= 1'b0;
        end
        else
        begin
            grant_q <= grant;
            if (grant)
                req.valid <= 1'b0;
            else if (host_req && !req.valid)
                req <= '{valid: 1'b1, we: host_we, addr: host_addr, wdata: host_wdata};
        end
    end

    always_ff @(posedge sda)
    begin
        if (grant_q)
            rdata_q <= rdata;
    end

    assign host_done = grant_q;
    // memory data is live in the done cycle, held afterwards.
    assign host_rdata = grant_q ? rdata : rdata_q;

    // the grant retires the pending access before done.
    a_done_after_grant: assert property (@(posedge sda) disable iff (!arst_n)
        host_done |-> $past(grant) && !req.valid);

endmodule

`default_nettype wire

//--- logic/memory_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter (
    input  wire                       sda,
    input  wire                       arst_n,
    input  wire eeprom_pkg::mem_req_t slave_req,
    input  wire eeprom_pkg::mem_req_t host_req,
    output logic                      slave_grant,
    output logic                      host_grant,
    output eeprom_pkg::mem_req_t      mem_req
);

    logic slave_owner; // owner of the read data now on the bus.
    logic host_owner;

    // serial side cannot wait, so it always wins.
    assign slave_grant = slave_req.valid;
    assign host_grant = host_req.valid && !slave_req.valid;
    assign mem_req = slave_req.valid ? slave_req : host_req;

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            slave_owner <= 1'b0;
            host_owner <= 1'b0;
        end
        else
        begin
            slave_owner <= slave_grant;
            host_owner <= host_grant;
        end
    end

    a_one_grant: assert property (@(posedge sda) disable iff (!arst_n)
        !(slave_grant && host_grant));

    // peers drop their request once granted.
    a_slave_pulse: assert property (@(posedge sda) disable iff (!arst_n)
        slave_owner |-> !slave_grant);

    a_host_pulse: assert property (@(posedge sda) disable iff (!arst_n)
        host_owner |-> !host_grant);

endmodule

`default_nettype wire

//--- logic/byte_memory.sv
`timescale 1ns/1ns
`default_nettype none

module byte_memory (
    input  wire                       sda,
    input  wire eeprom_pkg::mem_req_t mem_req,
    output eeprom_pkg::byte_t         rdata
);

    eeprom_pkg::byte_t mem [eeprom_pkg::mem_depth];

    // blank part reads as zero.
    initial
    begin
        for (int i = 0; i < eeprom_pkg::mem_depth; i++)
            mem[i] = '0;
    end

    always_ff @(posedge sda)
    begin
        if (mem_req.valid)
        begin
            if (mem_req.we)
                mem[mem_req.addr] <= mem_req.wdata;
            else
                rdata <= mem[mem_req.addr]; // valid the next cycle.
        end
    end

endmodule

`default_nettype wire

//--- logic/eeprom_top.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_top (
    input  wire                        sda,
    input  wire                        arst_n,
    input  wire                        scl,
    input  wire                        sdat_in,
    output logic                       sdat_pull,
    input  wire                        host_req,
    input  wire                        host_we,
    input  wire eeprom_pkg::mem_addr_t host_addr,
    input  wire eeprom_pkg::byte_t     host_wdata,
    output logic                       host_done,
    output eeprom_pkg::byte_t          host_rdata
);

    eeprom_pkg::line_events_t events;
    eeprom_pkg::mem_req_t     slave_req;
    eeprom_pkg::mem_req_t     port_req;
    eeprom_pkg::mem_req_t     mem_req;
    eeprom_pkg::byte_t        rdata;
    logic                     slave_grant;
    logic                     host_grant;

    bus_line_sync bus_line_sync_i (
        .sda     (sda),
        .arst_n  (arst_n),
        .scl     (scl),
        .sdat_in (sdat_in),
        .events  (events)
    );

    serial_slave serial_slave_i (
        .sda       (sda),
        .arst_n    (arst_n),
        .events    (events),
        .grant     (slave_grant),
        .rdata     (rdata),
        .req       (slave_req),
        .sdat_pull (sdat_pull)
    );

    host_port host_port_i (
        .sda        (sda),
        .arst_n     (arst_n),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .grant      (host_grant),
        .rdata      (rdata),
        .req        (port_req),
        .host_done  (host_done),
        .host_rdata (host_rdata)
    );

    memory_arbiter memory_arbiter_i (
        .sda         (sda),
        .arst_n      (arst_n),
        .slave_req   (slave_req),
        .host_req    (port_req),
        .slave_grant (slave_grant),
        .host_grant  (host_grant),
        .mem_req     (mem_req)
    );

    byte_memory byte_memory_i (
        .sda     (sda),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

//--- test/i2c_master.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_master (
    input  wire  sdat_pull,
    output logic scl,
    output wire  sdat_in
);

    logic drive; // master side of the open-drain line.

    assign sdat_in = drive && !sdat_pull;

    initial
    begin
        scl = 1'b1;
        drive = 1'b1;
    end

    // every step is a quarter of the 1 us scl period.
    task automatic start_cond();
    begin
        drive = 1'b1; // a repeated start begins with scl low.
        #250;
        scl = 1'b1;
        #250;
        drive = 1'b0;
        #250;
        scl = 1'b0;
        #250;
    end
    endtask

    task automatic stop_cond();
    begin
        drive = 1'b0;
        #250;
        scl = 1'b1;
        #250;
        drive = 1'b1;
        #250;
    end
    endtask

    task automatic send_bit(input logic b);
    begin
        drive = b;
        #250;
        scl = 1'b1;
        #500;
        scl = 1'b0;
        #250;
    end
    endtask

    task automatic recv_bit(output logic b);
    begin
        drive = 1'b1;
        #250;
        scl = 1'b1;
        #250;
        b = sdat_in; // middle of the high phase.
        #250;
        scl = 1'b0;
        #250;
    end
    endtask

    task automatic write_byte(input eeprom_pkg::byte_t data, output logic ack);
    begin
        for (int i = 7; i >= 0; i--)
            send_bit(data[i]);
        drive = 1'b1;
        #250;
        scl = 1'b1;
        ack = 1'b0;
        // watch the whole ack clock for a pull.
        for (int i = 0; i < 25; i++)
        begin
            #20;
            if (!sdat_in)
                ack = 1'b1;
        end
        scl = 1'b0;
        #250;
    end
    endtask

    task automatic read_byte(input logic ack, output eeprom_pkg::byte_t data);
        logic b;
    begin
        data = '0;
        for (int i = 0; i < 8; i++)
        begin
            recv_bit(b);
            data = {data[6:0], b}; // msb first.
        end
        send_bit(!ack);
    end
    endtask

endmodule

`default_nettype wire

//--- test/eeprom_tb.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_tb;

    logic                  sda;
    logic                  arst_n;
    logic                  scl;
    logic                  sdat_in;
    logic                  sdat_pull;
    logic                  host_req;
    logic                  host_we;
    eeprom_pkg::mem_addr_t host_addr;
    eeprom_pkg::byte_t     host_wdata;
    logic                  host_done;
    eeprom_pkg::byte_t     host_rdata;

    eeprom_pkg::byte_t     ref_mem [eeprom_pkg::mem_depth];
    eeprom_pkg::mem_addr_t serial_ptr; // where the slave pointer should be.
    eeprom_pkg::mem_addr_t addr;
    eeprom_pkg::block_t    blk;
    eeprom_pkg::byte_t     word;
    int                    errors;
    int                    checks;

    eeprom_top eeprom_top_i (
        .sda        (sda),
        .arst_n     (arst_n),
        .scl        (scl),
        .sdat_in    (sdat_in),
        .sdat_pull  (sdat_pull),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_done  (host_done),
        .host_rdata (host_rdata)
    );

    i2c_master i2c_master_i (
        .sdat_pull (sdat_pull),
        .scl       (scl),
        .sdat_in   (sdat_in)
    );

    initial
    begin
        sda = 1'b0;
        forever #20 sda = !sda;
    end

    // one done pulse per strobe.
    a_done_pulse: assert property (@(posedge sda) disable iff (!arst_n)
        host_done |=> !host_done)
    else
    begin
        errors++;
        $display("host_done stayed high for two cycles at %0t ns", $time);
    end

    task automatic check_byte(input string what, input eeprom_pkg::mem_addr_t a,
                              input eeprom_pkg::byte_t got);
    begin
        checks++;
        assert (got == ref_mem[a])
        else
        begin
            errors++;
            $display("[FAIL] %0t ns: %s at %0d returned %02h, expected %02h",
                     $time, what, a, got, ref_mem[a]);
        end
    end
    endtask

    task automatic expect_ack(input string what, input logic ack, input logic want);
    begin
        checks++;
        assert (ack == want)
        else
        begin
            errors++;
            $display("[FAIL] %0t ns: slave %s the %s byte",
                     $time, ack ? "acked" : "did not ack", what);
        end
    end
    endtask

    task automatic host_access(input logic we, input eeprom_pkg::mem_addr_t a,
                               input eeprom_pkg::byte_t wdata,
                               output eeprom_pkg::byte_t rdata);
        int waited;
    begin
        @(posedge sda);
        #2;
        host_req = 1'b1;
        host_we = we;
        host_addr = a;
        host_wdata = wdata;
        @(posedge sda);
        #2;
        host_req = 1'b0;
        waited = 0;
        @(negedge sda);
        while (!host_done && waited < 100)
        begin
            @(negedge sda);
            waited++;
        end
        if (!host_done)
        begin
            errors++;
            $display("timed out waiting for host_done after a host %s at address %0d",
                     we ? "write" : "read", a);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Test FAILED");
            $finish;
        end
        rdata = host_rdata;
    end
    endtask

    task automatic host_write(input eeprom_pkg::mem_addr_t a, input eeprom_pkg::byte_t d);
        eeprom_pkg::byte_t unused;
    begin
        host_access(1'b1, a, d, unused);
        ref_mem[a] = d;
    end
    endtask

    task automatic host_read(input eeprom_pkg::mem_addr_t a);
        eeprom_pkg::byte_t got;
    begin
        host_access(1'b0, a, '0, got);
        check_byte("host read", a, got);
    end
    endtask

    task automatic serial_write(input eeprom_pkg::block_t block,
                                input eeprom_pkg::byte_t word_addr, input int count);
        eeprom_pkg::mem_addr_t a;
        eeprom_pkg::byte_t     data;
        logic                  ack;
    begin
        @(posedge sda);
        #2;
        a = {block, word_addr};
        i2c_master_i.start_cond();
        i2c_master_i.write_byte({eeprom_pkg::device_code, block, 1'b0}, ack);
        expect_ack("control", ack, 1'b1);
        i2c_master_i.write_byte(word_addr, ack);
        expect_ack("word address", ack, 1'b1);
        for (int i = 0; i < count; i++)
        begin
            data = eeprom_pkg::byte_t'($urandom);
            i2c_master_i.write_byte(data, ack);
            expect_ack("data", ack, 1'b1);
            ref_mem[a] = data; // stored on the ack clock.
            a++;
        end
        serial_ptr = a;
        i2c_master_i.stop_cond();
    end
    endtask

    task automatic serial_read(input eeprom_pkg::block_t block, input logic set_ptr,
                               input eeprom_pkg::byte_t word_addr, input int count);
        eeprom_pkg::byte_t data;
        logic              ack;
    begin
        @(posedge sda);
        #2;
        i2c_master_i.start_cond();
        if (set_ptr)
        begin
            // dummy write loads the pointer.
            i2c_master_i.write_byte({eeprom_pkg::device_code, block, 1'b0}, ack);
            expect_ack("control", ack, 1'b1);
            i2c_master_i.write_byte(word_addr, ack);
            expect_ack("word address", ack, 1'b1);
            serial_ptr = {block, word_addr};
            i2c_master_i.start_cond();
        end
        i2c_master_i.write_byte({eeprom_pkg::device_code, block, 1'b1}, ack);
        expect_ack("read control", ack, 1'b1);
        for (int i = 0; i < count; i++)
        begin
            i2c_master_i.read_byte(i < count - 1, data); // nack on the last one.
            check_byte("serial read", serial_ptr, data);
            serial_ptr++;
        end
        i2c_master_i.stop_cond();
    end
    endtask

    task automatic foreign_write(input eeprom_pkg::block_t block,
                                 input eeprom_pkg::byte_t word_addr);
        logic ack;
    begin
        @(posedge sda);
        #2;
        i2c_master_i.start_cond();
        i2c_master_i.write_byte({4'b1011, block, 1'b0}, ack); // some other device.
        expect_ack("foreign control", ack, 1'b0);
        i2c_master_i.write_byte(word_addr, ack);
        expect_ack("foreign word address", ack, 1'b0);
        i2c_master_i.write_byte(~ref_mem[{block, word_addr}], ack);
        expect_ack("foreign data", ack, 1'b0);
        i2c_master_i.stop_cond();
    end
    endtask

    task automatic host_traffic(input int count);
        eeprom_pkg::mem_addr_t a;
    begin
        repeat (count)
        begin
            repeat ($urandom % 400) @(posedge sda);
            a = {1'b1, 10'($urandom)}; // upper half stays host only.
            if ($urandom % 2 == 0)
                host_write(a, eeprom_pkg::byte_t'($urandom));
            else
                host_read(a);
        end
    end
    endtask

    initial
    begin
        void'($urandom(32'ha60b0733));
        arst_n = 1'b0;
        host_req = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        errors = 0;
        checks = 0;
        serial_ptr = '0;
        for (int i = 0; i < eeprom_pkg::mem_depth; i++)
            ref_mem[i] = '0;
        repeat (5) @(posedge sda);
        #2;
        arst_n = 1'b1;

        blk = eeprom_pkg::block_t'($urandom);
        word = eeprom_pkg::byte_t'($urandom);
        serial_write(blk, word, 1);
        host_read({blk, word});
        blk = eeprom_pkg::block_t'($urandom);
        word = eeprom_pkg::byte_t'($urandom);
        serial_write(blk, word, 4);
        addr = {blk, word};
        repeat (4)
        begin
            host_read(addr);
            addr++;
        end

        addr = eeprom_pkg::mem_addr_t'($urandom);
        for (int i = 0; i < 3; i++)
            host_write(addr + eeprom_pkg::mem_addr_t'(i), eeprom_pkg::byte_t'($urandom));
        serial_read(addr[10:8], 1'b1, addr[7:0], 3);

        blk = eeprom_pkg::block_t'($urandom);
        word = eeprom_pkg::byte_t'($urandom);
        host_write({blk, word}, eeprom_pkg::byte_t'($urandom));
        foreign_write(blk, word);
        host_read({blk, word});

        addr = eeprom_pkg::mem_addr_t'(eeprom_pkg::mem_depth - 2);
        repeat (5)
        begin
            host_write(addr, eeprom_pkg::byte_t'($urandom));
            addr++;
        end
        serial_read(3'd7, 1'b1, 8'hfe, 4);
        serial_read(3'd0, 1'b0, 8'h00, 1); // current address after the wrap.

        repeat (2)
        begin
            blk = eeprom_pkg::block_t'($urandom % 4);
            word = eeprom_pkg::byte_t'($urandom % 240);
            fork
                begin
                    serial_write(blk, word, 4);
                    serial_read(blk, 1'b1, word, 4);
                end
                host_traffic(8);
            join
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/eeprom_pkg.sv
logic/bus_line_sync.sv
logic/serial_slave.sv
logic/host_port.sv
logic/memory_arbiter.sv
logic/byte_memory.sv
logic/eeprom_top.sv
test/i2c_master.sv
test/eeprom_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module eeprom_tb \
    -f filelist.f -o eeprom_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/eeprom_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    exit 1
fi
exit 0
